//--- Makefile
SIM := verilator
SIM_FLAGS := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
TOP := sincos_tb
FILE_LIST := sim.f
BUILD_DIR := obj_dir
RUN_FLAGS := +verilator+error+limit+1000
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q ">>> PASS" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/angle_wrap.sv
// input stage: wraps the angle to sine and cosine phases in [-pi, pi) with a valid strobe
`timescale 1ns/1ns

module angle_wrap (
	input logic clk,
	input logic reset,
	input logic en,
	input logic in_valid,
	input trig_pkg::fixed_t angle,
	output trig_pkg::fixed_t sin_phase,
	output trig_pkg::fixed_t cos_phase,
	output logic phase_valid
);

	import trig_pkg::*;

	fixed_t sin_wrapped;
	fixed_t cos_shifted;
	fixed_t cos_wrapped;

	// one fold of 2 pi is enough for inputs within +-2 pi
	function automatic fixed_t wrap_phase(input fixed_t phase);
		fixed_t wrapped;
		if (phase >= ANGLE_PI) begin
			wrapped = phase - ANGLE_TWO_PI;
		end else if (phase < -ANGLE_PI) begin
			wrapped = phase + ANGLE_TWO_PI;
		end else begin
			wrapped = phase;
		end
		return wrapped;
	endfunction

	assign sin_wrapped = wrap_phase(angle);

	// cos(x) = sin(x + pi/2), shifted phase lands in [-pi/2, 3pi/2)
	assign cos_shifted = sin_wrapped + ANGLE_HALF_PI;
	assign cos_wrapped = wrap_phase(cos_shifted);

	always_ff @(posedge clk) begin
		if (en) begin
			sin_phase <= sin_wrapped;
			cos_phase <= cos_wrapped;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			phase_valid <= 1'b0;
		end else if (en) begin
			phase_valid <= in_valid;
		end
	end

endmodule

//--- design/delay_line.sv
// enable-gated shift register with configurable depth, payload type and optional reset
`timescale 1ns/1ns

module delay_line #(
	parameter type payload_t = logic,
	parameter int DEPTH = 1,
	parameter bit RESETTABLE = 1'b0
) (
	input logic clk,
	input logic reset,
	input logic en,
	input payload_t d,
	output payload_t q
);

	payload_t stages [DEPTH];

	always_ff @(posedge clk) begin
		if (RESETTABLE && reset) begin
			for (int i = 0; i < DEPTH; i++) begin
				stages[i] <= payload_t'(0);
			end
		end else if (en) begin
			stages[0] <= d;
			for (int i = 1; i < DEPTH; i++) begin
				stages[i] <= stages[i-1];
			end
		end
	end

	assign q = stages[DEPTH-1];

endmodule

//--- design/fixed_scale.sv
// pipelined multiply by a constant fixed-point coefficient with rounding stage
`timescale 1ns/1ns

module fixed_scale #(
	parameter int MULT_LATENCY = 3,
	parameter trig_pkg::fixed_t COEF = trig_pkg::COEF_LIN
) (
	input logic clk,
	input logic en,
	input trig_pkg::fixed_t a,
	output trig_pkg::fixed_t result
);

	import trig_pkg::*;

	// constant operand folds into the multiplier
	product_t prod_pipe [MULT_LATENCY];

	always_ff @(posedge clk) begin
		if (en) begin
			prod_pipe[0] <= a * COEF;
			for (int i = 1; i < MULT_LATENCY; i++) begin
				prod_pipe[i] <= prod_pipe[i-1];
			end
		end
	end

	// same rounding rule as the squarer
	always_ff @(posedge clk) begin
		if (en) begin
			result <= round_product(prod_pipe[MULT_LATENCY-1]);
		end
	end

endmodule

//--- design/fixed_square.sv
// pipelined signed fixed-point squarer with rounding stage
`timescale 1ns/1ns

module fixed_square #(
	parameter int MULT_LATENCY = 3
) (
	input logic clk,
	input logic en,
	input trig_pkg::fixed_t a,
	output trig_pkg::fixed_t result
);

	import trig_pkg::*;

	// product stages, retimed into the multiplier by synthesis
	product_t prod_pipe [MULT_LATENCY];

	always_ff @(posedge clk) begin
		if (en) begin
			prod_pipe[0] <= a * a;
			for (int i = 1; i < MULT_LATENCY; i++) begin
				prod_pipe[i] <= prod_pipe[i-1];
			end
		end
	end

	// rounding stage back to 8 fraction bits
	always_ff @(posedge clk) begin
		if (en) begin
			result <= round_product(prod_pipe[MULT_LATENCY-1]);
		end
	end

endmodule

//--- design/sincos_unit.sv
// top level: angle wrap, sine and cosine pipelines, valid strobe delay
`timescale 1ns/1ns

module sincos_unit #(
	parameter int MULT_LATENCY = 3
) (
	input logic clk,
	input logic reset,
	input logic en,
	input logic in_valid,
	input trig_pkg::fixed_t angle,
	output logic out_valid,
	output trig_pkg::sincos_t result
);

	import trig_pkg::*;

	// latency of one sine pipeline
	localparam int SINE_LATENCY = 4 * MULT_LATENCY + 8;

	fixed_t sin_phase;
	fixed_t cos_phase;
	logic phase_valid;
	fixed_t sin_value;
	fixed_t cos_value;

	angle_wrap angle_wrap_inst (
		.clk(clk),
		.reset(reset),
		.en(en),
		.in_valid(in_valid),
		.angle(angle),
		.sin_phase(sin_phase),
		.cos_phase(cos_phase),
		.phase_valid(phase_valid)
	);

	sine_approx #(
		.MULT_LATENCY(MULT_LATENCY)
	) sin_approx_inst (
		.clk(clk),
		.en(en),
		.angle(sin_phase),
		.sin(sin_value)
	);

	// cosine is the sine of the shifted phase
	sine_approx #(
		.MULT_LATENCY(MULT_LATENCY)
	) cos_approx_inst (
		.clk(clk),
		.en(en),
		.angle(cos_phase),
		.sin(cos_value)
	);

	delay_line #(
		.payload_t(logic),
		.DEPTH(SINE_LATENCY),
		.RESETTABLE(1'b1)
	) valid_delay_inst (
		.clk(clk),
		.reset(reset),
		.en(en),
		.d(phase_valid),
		.q(out_valid)
	);

	assign result = '{sin: sin_value, cos: cos_value};

endmodule

//--- design/sine_approx.sv
// parabolic sine approximation pipeline with refinement step
`timescale 1ns/1ns

module sine_approx #(
	parameter int MULT_LATENCY = 3
) (
	input logic clk,
	input logic en,
	input trig_pkg::fixed_t angle,
	output trig_pkg::fixed_t sin
);

	import trig_pkg::*;

	// multiplier plus rounding register
	localparam int STAGE_LATENCY = MULT_LATENCY + 1;

	fixed_t angle_sq;
	fixed_t quad_term;
	fixed_t lin_term;
	fixed_t lin_term_d;
	fixed_t angle_d;
	fixed_t est;
	fixed_t est_sq;
	fixed_t est_sign_d;
	fixed_t est_sq_norm;
	fixed_t est_diff_d;
	fixed_t est_diff;
	fixed_t refine_term;
	fixed_t est_sum_d;

	// x * x
	fixed_square #(
		.MULT_LATENCY(MULT_LATENCY)
	) angle_square_inst (
		.clk(clk),
		.en(en),
		.a(angle),
		.result(angle_sq)
	);

	// 0.405 * x * x
	fixed_scale #(
		.MULT_LATENCY(MULT_LATENCY),
		.COEF(COEF_QUAD)
	) quad_scale_inst (
		.clk(clk),
		.en(en),
		.a(angle_sq),
		.result(quad_term)
	);

	// 1.273 * x, ready one multiplier early
	fixed_scale #(
		.MULT_LATENCY(MULT_LATENCY),
		.COEF(COEF_LIN)
	) lin_scale_inst (
		.clk(clk),
		.en(en),
		.a(angle),
		.result(lin_term)
	);

	// line up the linear term with the quadratic path
	delay_line #(
		.payload_t(fixed_t),
		.DEPTH(STAGE_LATENCY)
	) lin_delay_inst (
		.clk(clk),
		.reset(1'b0),
		.en(en),
		.d(lin_term),
		.q(lin_term_d)
	);

	// x itself only needed for its sign
	delay_line #(
		.payload_t(fixed_t),
		.DEPTH(2 * STAGE_LATENCY)
	) angle_delay_inst (
		.clk(clk),
		.reset(1'b0),
		.en(en),
		.d(angle),
		.q(angle_d)
	);

	// negative x adds the quadratic term, positive x subtracts it
	always_ff @(posedge clk) begin
		if (en) begin
			est <= angle_d[FIXED_WIDTH-1] ? lin_term_d + quad_term : lin_term_d - quad_term;
		end
	end

	// est * est
	fixed_square #(
		.MULT_LATENCY(MULT_LATENCY)
	) est_square_inst (
		.clk(clk),
		.en(en),
		.a(est),
		.result(est_sq)
	);

	// est for the sign correction
	delay_line #(
		.payload_t(fixed_t),
		.DEPTH(STAGE_LATENCY)
	) est_sign_delay_inst (
		.clk(clk),
		.reset(1'b0),
		.en(en),
		.d(est),
		.q(est_sign_d)
	);

	// est for the difference, one stage later
	delay_line #(
		.payload_t(fixed_t),
		.DEPTH(1)
	) est_diff_delay_inst (
		.clk(clk),
		.reset(1'b0),
		.en(en),
		.d(est_sign_d),
		.q(est_diff_d)
	);

	// est * |est|, then the difference from est
	always_ff @(posedge clk) begin
		if (en) begin
			est_sq_norm <= est_sign_d[FIXED_WIDTH-1] ? -est_sq : est_sq;
			est_diff <= est_sq_norm - est_diff_d;
		end
	end

	// 0.225 * (est * |est| - est)
	fixed_scale #(
		.MULT_LATENCY(MULT_LATENCY),
		.COEF(COEF_REFINE)
	) refine_scale_inst (
		.clk(clk),
		.en(en),
		.a(est_diff),
		.result(refine_term)
	);

	// est held across the refinement multiplier
	delay_line #(
		.payload_t(fixed_t),
		.DEPTH(STAGE_LATENCY + 1)
	) est_sum_delay_inst (
		.clk(clk),
		.reset(1'b0),
		.en(en),
		.d(est_diff_d),
		.q(est_sum_d)
	);

	always_ff @(posedge clk) begin
		if (en) begin
			sin <= refine_term + est_sum_d;
		end
	end

endmodule

//--- design/trig_pkg.sv
// fixed-point types, sin/cos result struct, coefficients, angle constants, product rounding
package trig_pkg;

	localparam int FIXED_WIDTH = 27;
	localparam int FRAC_BITS = 8;
	localparam int PRODUCT_WIDTH = 2 * FIXED_WIDTH;

	// radians and results, 8 fraction bits
	typedef logic signed [FIXED_WIDTH-1:0] fixed_t;

	// full-width signed product before rounding
	typedef logic signed [PRODUCT_WIDTH-1:0] product_t;

	typedef struct packed {
		fixed_t sin;
		fixed_t cos;
	} sincos_t;

	// parabola coefficients scaled by 256
	localparam fixed_t COEF_LIN = 27'sd326;
	localparam fixed_t COEF_QUAD = 27'sd104;
	localparam fixed_t COEF_REFINE = 27'sd58;

	// angle constants scaled by 256
	localparam fixed_t ANGLE_PI = 27'sd804;
	localparam fixed_t ANGLE_HALF_PI = 27'sd402;
	localparam fixed_t ANGLE_TWO_PI = 27'sd1608;

	// keep bits 34..8 of the product, round half up on bit 7
	function automatic fixed_t round_product(input product_t p);
		fixed_t kept;
		kept = p[FRAC_BITS +: FIXED_WIDTH];
		return kept + fixed_t'(p[FRAC_BITS-1]);
	endfunction

endpackage

//--- sim.f
design/trig_pkg.sv
design/fixed_square.sv
design/fixed_scale.sv
design/delay_line.sv
design/angle_wrap.sv
design/sine_approx.sv
design/sincos_unit.sv
test/sincos_assertions.sv
test/sincos_tb.sv

//--- test/sincos_assertions.sv
// concurrent checks on the sincos_unit valid strobe and result, bound to the top level
`timescale 1ns/1ns

module sincos_assertions (
	input logic clk,
	input logic reset,
	input logic en,
	input logic out_valid,
	input trig_pkg::sincos_t result
);

	int error_count = 0;

	// synchronous reset clears the valid delay line
	valid_low_in_reset: assert property (
		@(posedge clk) reset |=> !out_valid
	) else begin
		$error("out_valid high after a reset cycle");
		error_count++;
	end

	// stalled pipeline holds its outputs
	valid_stable_on_stall: assert property (
		@(posedge clk) disable iff (reset) !en |=> $stable(out_valid)
	) else begin
		$error("out_valid changed while en was low");
		error_count++;
	end

	result_stable_on_stall: assert property (
		@(posedge clk) disable iff (reset) (!en && out_valid) |=> $stable(result)
	) else begin
		$error("result changed while en was low");
		error_count++;
	end

	result_known: assert property (
		@(posedge clk) disable iff (reset) out_valid |-> !$isunknown(result)
	) else begin
		$error("result has unknown bits with out_valid high");
		error_count++;
	end

endmodule

bind sincos_unit sincos_assertions sincos_assertions_inst (
	.clk(clk),
	.reset(reset),
	.en(en),
	.out_valid(out_valid),
	.result(result)
);

//--- test/sincos_tb.sv
// sincos_unit testbench with clock, reset, stimulus, reference model, scoreboard and check tasks
`timescale 1ns/1ns

module sincos_tb;

	import trig_pkg::*;

	localparam int MULT_LATENCY = 3;
	localparam int WAIT_LIMIT = 2000;
	localparam int RANDOM_COUNT = 200;

	logic clk;
	logic reset;
	logic en;
	logic in_valid;
	fixed_t angle;
	logic out_valid;
	sincos_t result;

	// scoreboard state
	sincos_t expected_q[$];
	string name_q[$];
	string test_name;
	int sent_count;
	int recv_count;
	int seed;

	// 0, +-pi/2, +-pi/4, just inside +-pi
	fixed_t directed_angles[9] = '{
		27'sd0, 27'sd402, -27'sd402, 27'sd201, -27'sd201,
		27'sd803, -27'sd804, 27'sd800, -27'sd800
	};

	// beyond +-pi, up to the input range limits
	fixed_t wrap_angles[10] = '{
		27'sd804, -27'sd805, 27'sd1000, -27'sd1000, 27'sd1206,
		-27'sd1206, 27'sd1607, -27'sd1608, 27'sd1205, -27'sd1300
	};

	sincos_unit #(
		.MULT_LATENCY(MULT_LATENCY)
	) sincos_unit_inst (
		.clk(clk),
		.reset(reset),
		.en(en),
		.in_valid(in_valid),
		.angle(angle),
		.out_valid(out_valid),
		.result(result)
	);

	always begin
		clk = 1'b0;
		#4;
		clk = 1'b1;
		#4;
	end

	// product scaled back to 8 fraction bits, half rounded up
	function automatic fixed_t fixed_mul(input fixed_t a, input fixed_t b);
		longint prod;
		fixed_t kept;
		prod = longint'(a) * longint'(b);
		kept = fixed_t'(prod >>> FRAC_BITS);
		kept = kept + fixed_t'((prod >>> (FRAC_BITS - 1)) & 64'sd1);
		return kept;
	endfunction

	// bring a phase into [-pi, pi) with one step of 2 pi
	function automatic fixed_t fold_phase(input fixed_t phase);
		int p;
		p = int'(phase);
		if (p >= int'(ANGLE_PI)) begin
			p = p - int'(ANGLE_TWO_PI);
		end else if (p < -int'(ANGLE_PI)) begin
			p = p + int'(ANGLE_TWO_PI);
		end
		return fixed_t'(p);
	endfunction

	// parabola first, then the 0.225 correction
	function automatic fixed_t sine_model(input fixed_t x);
		fixed_t quad;
		fixed_t lin;
		fixed_t est;
		fixed_t est_abs_sq;
		fixed_t refine;
		quad = fixed_mul(fixed_mul(x, x), COEF_QUAD);
		lin = fixed_mul(x, COEF_LIN);
		est = (x < 0) ? lin + quad : lin - quad;
		est_abs_sq = fixed_mul(est, est);
		if (est < 0) begin
			est_abs_sq = -est_abs_sq;
		end
		refine = fixed_mul(est_abs_sq - est, COEF_REFINE);
		return est + refine;
	endfunction

	function automatic sincos_t ref_sincos(input fixed_t a);
		fixed_t sin_phase;
		fixed_t cos_phase;
		sincos_t expected;
		sin_phase = fold_phase(a);
		cos_phase = fold_phase(sin_phase + ANGLE_HALF_PI);
		expected.sin = sine_model(sin_phase);
		expected.cos = sine_model(cos_phase);
		return expected;
	endfunction

	// uniform over [-2 pi, 2 pi)
	function automatic fixed_t random_angle();
		int r;
		r = {$random(seed)} % (2 * int'(ANGLE_TWO_PI));
		return fixed_t'(r - int'(ANGLE_TWO_PI));
	endfunction

	task automatic abort_run();
		$display(">>> FAIL");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_sincos(input string name, input sincos_t expected, input sincos_t actual);
		if (expected !== actual) begin
			$display("FAILED %s: expected sin=%0d cos=%0d, actual sin=%0d cos=%0d",
				name, expected.sin, expected.cos, actual.sin, actual.cos);
			abort_run();
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (expected != actual) begin
			$display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
			abort_run();
		end
	endtask

	task automatic send_angle(input string name, input fixed_t value);
		@(posedge clk);
		test_name <= name;
		angle <= value;
		in_valid <= 1'b1;
		en <= 1'b1;
		sent_count++;
	endtask

	// up to three stalled cycles before the angle with in_valid toggling
	task automatic send_with_stall(input string name, input fixed_t value);
		int stall;
		stall = {$random(seed)} % 4;
		repeat (stall) begin
			@(posedge clk);
			en <= 1'b0;
			in_valid <= ($random(seed) & 1) != 0;
		end
		send_angle(name, value);
	endtask

	task automatic idle_cycles(input int count);
		repeat (count) begin
			@(posedge clk);
			in_valid <= 1'b0;
			en <= 1'b1;
		end
	endtask

	task automatic wait_drained(input string name);
		int cycles;
		cycles = 0;
		while (recv_count < sent_count && cycles < WAIT_LIMIT) begin
			@(posedge clk);
			in_valid <= 1'b0;
			en <= 1'b1;
			cycles++;
		end
		if (recv_count < sent_count) begin
			$display("timeout in %s: %0d results never came out", name, sent_count - recv_count);
			abort_run();
		end
	endtask

	// input side of the scoreboard
	always @(posedge clk) begin
		if (!reset && in_valid && en) begin
			expected_q.push_back(ref_sincos(angle));
			name_q.push_back(test_name);
		end
	end

	// output side takes one result per enabled edge with out_valid high
	always @(posedge clk) begin
		if (!reset && en && out_valid) begin
			if (expected_q.size() == 0) begin
				$display("out_valid was high with no angle in flight (%s)", test_name);
				abort_run();
			end else begin
				check_sincos(name_q.pop_front(), expected_q.pop_front(), result);
				recv_count++;
			end
		end
	end

	always @(posedge clk) begin
		if (sincos_unit_inst.sincos_assertions_inst.error_count != 0) begin
			$display("a bound assertion on sincos_unit failed");
			abort_run();
		end
	end

	initial begin
		seed = 72;
		sent_count = 0;
		recv_count = 0;
		test_name = "reset";
		reset = 1'b1;
		en = 1'b0;
		in_valid = 1'b0;
		angle = '0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		// nothing may come out before the first angle
		test_name <= "after_reset";
		idle_cycles(40);

		foreach (directed_angles[i]) begin
			send_angle("directed", directed_angles[i]);
		end
		wait_drained("directed");

		foreach (wrap_angles[i]) begin
			send_angle("wrap", wrap_angles[i]);
		end
		wait_drained("wrap");

		// burst, gap, burst, then silence
		repeat (5) send_angle("gap", random_angle());
		idle_cycles(12);
		repeat (5) send_angle("gap", random_angle());
		wait_drained("gap");
		idle_cycles(40);

		repeat (RANDOM_COUNT) send_angle("random_stream", random_angle());
		wait_drained("random_stream");

		repeat (RANDOM_COUNT) send_with_stall("random_stall", random_angle());
		wait_drained("random_stall");
		idle_cycles(30);

		check_count("output_count", sent_count, recv_count);

		if (sincos_unit_inst.sincos_assertions_inst.error_count != 0) begin
			$display("bound assertions reported failures");
			abort_run();
		end else begin
			$display(">>> PASS");
			$finish;
		end
	end

endmodule
